/* debug_tests.txt */
# Columns: name, mode (run or step), program words, halt cycle or step count,
# largest credit return delay in cycles.
run_short        run   3   5  0
run_long         run  16  40  3
run_slow_host    run   8  12  9
run_one_word     run   1   1  1
step_single      step  2   1  0
step_three       step  5   3  2
step_slow_host   step  4   2  7
run_big_program  run  40  25  4

/* sources.f */
debug_pkg.sv
rx_command_decoder.sv
program_loader.sv
host_tx_engine.sv
debug_control_fsm.sv
debug_unit_top.sv
tb_debug_unit.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_debug_unit -f sources.f -o tb_debug_unit
./obj_dir/tb_debug_unit > sim.log 2>&1 || true
cat sim.log
if grep -qx "NO ERRORS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tb_debug_unit.sv */
`timescale 1ns/1ps

module tb_debug_unit import debug_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 2;
    localparam int ACK_DELAY    = 3;  // Processor model acknowledges in its third reset cycle.

    logic                   clock;
    logic                   reset;
    logic                   rx_done;
    logic [BYTE_W-1:0]      rx_data;
    logic                   cpu_reset_ack;
    logic                   cpu_halt;
    logic [WORD_W-1:0]      dump_word;
    logic                   tx_credit;
    logic                   cpu_reset;
    logic                   cpu_enable;
    logic                   prog_write;
    logic [PROG_ADDR_W-1:0] prog_addr;
    logic [WORD_W-1:0]      prog_data;
    logic [DUMP_IDX_W-1:0]  dump_index;
    logic                   tx_valid;
    logic [BYTE_W-1:0]      tx_data;

    // One entry per line of the test file.
    string t_name[$];
    string t_mode[$];
    int    t_words[$];
    int    t_halt[$];
    int    t_delay[$];

    string cur_name;
    int    test_num;
    int    errors;
    int    checks;
    int    budget_cycles;
    int    cycle;
    int    t;

    int    enable_cnt;  // Processor model state.
    int    reset_cnt;
    int    halt_limit;

    logic [BYTE_W-1:0]             rx_bytes[$];  // Host model state.
    int                            credit_due[$];
    int                            credit_at;
    int                            max_delay;
    int                            bytes_seen;
    int                            credits_given;
    logic [PROG_ADDR_W+WORD_W-1:0] writes[$];

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    debug_unit_top u_debug_unit_top (
        .i_clock         (clock),
        .i_reset         (reset),
        .i_rx_done       (rx_done),
        .i_rx_data       (rx_data),
        .i_cpu_reset_ack (cpu_reset_ack),
        .i_cpu_halt      (cpu_halt),
        .i_dump_word     (dump_word),
        .i_tx_credit     (tx_credit),
        .o_cpu_reset     (cpu_reset),
        .o_cpu_enable    (cpu_enable),
        .o_prog_write    (prog_write),
        .o_prog_addr     (prog_addr),
        .o_prog_data     (prog_data),
        .o_dump_index    (dump_index),
        .o_tx_valid      (tx_valid),
        .o_tx_data       (tx_data)
    );

    //////////////////////////////////////////////////
    // Processor, register bank and host models
    //////////////////////////////////////////////////

    // Register bank contents depend on test, index and executed cycles.
    function automatic logic [WORD_W-1:0] bank_word(int test, int idx, int count);
        bank_word = {8'(test + 1), 8'(idx * 17), 16'(count)};
    endfunction

    assign dump_word = bank_word(test_num, int'(dump_index), enable_cnt);

    always @(posedge clock) begin
        #(DRIVE_DELAY);
        cycle = cycle + 1;
        if (cpu_reset) begin
            reset_cnt     = reset_cnt + 1;
            enable_cnt    = 0;
            cpu_halt      = 1'b0;
            cpu_reset_ack = reset_cnt >= ACK_DELAY;
        end else begin
            reset_cnt     = 0;
            cpu_reset_ack = 1'b0;
        end
        if (cpu_enable) begin
            enable_cnt = enable_cnt + 1;  // This cycle executes.
            if (enable_cnt >= halt_limit) begin
                cpu_halt = 1'b1;
            end
        end
        tx_credit = 1'b0;
        if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
            void'(credit_due.pop_front());
            tx_credit     = 1'b1;
            credits_given = credits_given + 1;
        end
    end

    always @(negedge clock) begin
        if (tx_valid) begin
            rx_bytes.push_back(tx_data);
            bytes_seen = bytes_seen + 1;
            credit_at  = cycle + 1 + $urandom_range(max_delay, 0);
            if (credit_due.size() > 0 && credit_at <= credit_due[$]) begin
                credit_at = credit_due[$] + 1;  // One credit pulse per cycle.
            end
            credit_due.push_back(credit_at);
            if (bytes_seen - credits_given > TX_CREDITS) begin
                errors = errors + 1;
                $display("Test %s: %0d bytes outstanding, more than the %0d credits",
                         cur_name, bytes_seen - credits_given, TX_CREDITS);
            end
        end
        if (prog_write) begin
            writes.push_back({prog_addr, prog_data});
        end
    end

    //////////////////////////////////////////////////
    // Tasks
    //////////////////////////////////////////////////

    task automatic compare_value(string what, logic [31:0] exp, logic [31:0] act);
        checks = checks + 1;
        if (exp !== act) begin
            errors = errors + 1;
            $display("FAIL %s %s: expected %h, actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic read_tests();
        int    fd;
        int    got;
        int    n;
        int    h;
        int    d;
        int    sum;
        string line;
        string name;
        string mode;
        fd  = $fopen("debug_tests.txt", "r");
        sum = 200;
        if (fd == 0) begin
            errors = errors + 1;
            $display("Cannot open the test file debug_tests.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got  = $fgets(line, fd);
                if (got > 0 && line.len() > 1 && line[0] != "#") begin
                    got = $sscanf(line, "%s %s %d %d %d", name, mode, n, h, d);
                    if (got == 5) begin
                        t_name.push_back(name);
                        t_mode.push_back(mode);
                        t_words.push_back(n);
                        t_halt.push_back(h);
                        t_delay.push_back(d);
                        // Load, run and every dump at the slowest credit return.
                        sum = sum + 300 + 20 * (n + 1) + h
                            + ((mode == "step") ? h : 1) * (48 * (d + 4) + 50);
                    end
                end
            end
            $fclose(fd);
        end
        budget_cycles = sum;
    endtask

    task automatic send_byte(logic [BYTE_W-1:0] b);
        @(posedge clock);
        #(DRIVE_DELAY);
        rx_data = b;
        rx_done = 1'b1;
        @(posedge clock);
        #(DRIVE_DELAY);
        rx_done = 1'b0;  // Byte counts on this fall.
        repeat (2) @(posedge clock);
    endtask

    task automatic take_byte(output logic [BYTE_W-1:0] b);
        while (rx_bytes.size() == 0) begin
            @(negedge clock);
        end
        b = rx_bytes.pop_front();
    endtask

    task automatic soft_reset();
        int                high;
        logic [BYTE_W-1:0] b;
        high = 0;
        send_byte(CMD_RESET);
        while (!cpu_reset) begin
            @(negedge clock);
        end
        while (cpu_reset) begin
            high = high + 1;
            @(negedge clock);
        end
        compare_value("reset pulse cycles", ACK_DELAY, high);
        take_byte(b);
        compare_value("ready byte", READY_BYTE, b);
    endtask

    task automatic load_program(int n);
        int                            i;
        int                            k;
        logic [WORD_W-1:0]             w;
        logic [WORD_W-1:0]             prog[$];
        logic [PROG_ADDR_W+WORD_W-1:0] wr;
        for (i = 0; i < n; i++) begin
            w = $urandom();
            if (w == HALT_WORD) begin
                w = '0;
            end
            prog.push_back(w);
        end
        prog.push_back(HALT_WORD);
        writes.delete();
        send_byte(CMD_LOAD);
        for (i = 0; i <= n; i++) begin
            for (k = BYTES_PER_WORD - 1; k >= 0; k--) begin
                send_byte(prog[i][k*BYTE_W +: BYTE_W]);  // Top byte first.
            end
        end
        while (writes.size() < n + 1) begin
            @(negedge clock);
        end
        for (i = 0; i <= n; i++) begin
            wr = writes.pop_front();
            compare_value($sformatf("write %0d address", i), i, wr[WORD_W +: PROG_ADDR_W]);
            compare_value($sformatf("write %0d data", i), prog[i], wr[WORD_W-1:0]);
        end
    endtask

    task automatic check_dump(int count);
        int                idx;
        int                k;
        logic [WORD_W-1:0] exp;
        logic [BYTE_W-1:0] b;
        for (idx = 0; idx < DUMP_WORDS; idx++) begin
            exp = bank_word(test_num, idx, count);
            for (k = BYTES_PER_WORD - 1; k >= 0; k--) begin
                take_byte(b);
                compare_value($sformatf("dump %0d byte %0d", idx, 3 - k),
                              exp[k*BYTE_W +: BYTE_W], b);
            end
        end
    endtask

    task automatic run_test(int num);
        int s;
        cur_name   = t_name[num];
        test_num   = num;
        max_delay  = t_delay[num];
        halt_limit = t_halt[num];  // Halt cycle, or the step that halts.
        soft_reset();
        load_program(t_words[num]);
        if (t_mode[num] == "run") begin
            send_byte(CMD_RUN);
            check_dump(t_halt[num]);
            compare_value("enable cycles", t_halt[num], enable_cnt);
        end else begin
            for (s = 1; s <= t_halt[num]; s++) begin
                send_byte(CMD_STEP);
                check_dump(s);
                compare_value("enable cycles", s, enable_cnt);
            end
        end
        compare_value("writes after halt word", 0, writes.size());
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        reset         = 1'b0;
        rx_done       = 1'b0;
        rx_data       = '0;
        cpu_reset_ack = 1'b0;
        cpu_halt      = 1'b0;
        tx_credit     = 1'b0;
        errors        = 0;
        checks        = 0;
        cycle         = 0;
        enable_cnt    = 0;
        reset_cnt     = 0;
        halt_limit    = 0;
        max_delay     = 0;
        bytes_seen    = 0;
        credits_given = 0;
        test_num      = 0;
        budget_cycles = 0;
        cur_name      = "power_on";
        void'($urandom(32'h24448ced));
        read_tests();
        compare_value("tests in file", 1, t_name.size() > 0);
        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        reset = 1'b1;
        repeat (4) begin
            @(negedge clock);
            compare_value("idle outputs", 0, {cpu_reset, cpu_enable, prog_write, tx_valid});
        end
        for (t = 0; t < t_name.size(); t++) begin
            run_test(t);
        end
        cur_name = "final_reset";
        soft_reset();  // Unit is back in idle after the last dump.
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (budget_cycles > 0);
        repeat (budget_cycles) @(posedge clock);
        $display("Timeout after %0d cycles, the test sequence did not finish", budget_cycles);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* debug_unit_top.sv */
`timescale 1ns/1ps

module debug_unit_top import debug_pkg::*; (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_rx_done,
    input  logic [BYTE_W-1:0]      i_rx_data,
    input  logic                   i_cpu_reset_ack,
    input  logic                   i_cpu_halt,
    input  logic [WORD_W-1:0]      i_dump_word,
    input  logic                   i_tx_credit,
    output logic                   o_cpu_reset,
    output logic                   o_cpu_enable,
    output logic                   o_prog_write,
    output logic [PROG_ADDR_W-1:0] o_prog_addr,
    output logic [WORD_W-1:0]      o_prog_data,
    output logic [DUMP_IDX_W-1:0]  o_dump_index,
    output logic                   o_tx_valid,
    output logic [BYTE_W-1:0]      o_tx_data
);

    logic              byte_strobe;
    logic [BYTE_W-1:0] rx_byte;
    cmd_e              rx_cmd;
    logic              load_active;
    logic              load_done;
    logic              send_ready;
    logic              dump_start;
    logic              tx_busy;

    rx_command_decoder u_rx_command_decoder (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_rx_done     (i_rx_done),
        .i_rx_data     (i_rx_data),
        .o_byte_strobe (byte_strobe),
        .o_rx_byte     (rx_byte),
        .o_rx_cmd      (rx_cmd)
    );

    program_loader u_program_loader (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_load_active (load_active),
        .i_byte_strobe (byte_strobe),
        .i_rx_byte     (rx_byte),
        .o_prog_write  (o_prog_write),
        .o_prog_addr   (o_prog_addr),
        .o_prog_data   (o_prog_data),
        .o_load_done   (load_done)
    );

    host_tx_engine u_host_tx_engine (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_send_ready (send_ready),
        .i_dump_start (dump_start),
        .i_tx_credit  (i_tx_credit),
        .i_dump_word  (i_dump_word),
        .o_tx_valid   (o_tx_valid),
        .o_tx_data    (o_tx_data),
        .o_dump_index (o_dump_index),
        .o_tx_busy    (tx_busy)
    );

    debug_control_fsm u_debug_control_fsm (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_byte_strobe   (byte_strobe),
        .i_rx_cmd        (rx_cmd),
        .i_cpu_reset_ack (i_cpu_reset_ack),
        .i_cpu_halt      (i_cpu_halt),
        .i_load_done     (load_done),
        .i_tx_busy       (tx_busy),
        .o_cpu_reset     (o_cpu_reset),
        .o_cpu_enable    (o_cpu_enable),
        .o_load_active   (load_active),
        .o_send_ready    (send_ready),
        .o_dump_start    (dump_start)
    );

endmodule

/* debug_control_fsm.sv */
`timescale 1ns/1ps

module debug_control_fsm import debug_pkg::*; (
    input  logic i_clock,
    input  logic i_reset,
    input  logic i_byte_strobe,
    input  cmd_e i_rx_cmd,
    input  logic i_cpu_reset_ack,
    input  logic i_cpu_halt,
    input  logic i_load_done,
    input  logic i_tx_busy,
    output logic o_cpu_reset,
    output logic o_cpu_enable,
    output logic o_load_active,
    output logic o_send_ready,
    output logic o_dump_start
);

    state_e state_q;
    state_e next_state;
    logic   step_mode_q;  // 1 for single step, 0 for continuous.
    logic   cmd_reset;
    logic   cmd_load;
    logic   cmd_run;
    logic   cmd_step;
    logic   run_done;

    assign cmd_reset = i_byte_strobe && (i_rx_cmd == CMD_RESET);
    assign cmd_load  = i_byte_strobe && (i_rx_cmd == CMD_LOAD);
    assign cmd_run   = i_byte_strobe && (i_rx_cmd == CMD_RUN);
    assign cmd_step  = i_byte_strobe && (i_rx_cmd == CMD_STEP);

    // A step lasts one cycle; a run lasts until halt.
    assign run_done = (state_q == ST_RUN) && (step_mode_q || i_cpu_halt);

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        next_state = state_q;
        case (state_q)
            ST_IDLE:       if (cmd_reset)           next_state = ST_SOFT_RESET;
            ST_SOFT_RESET: if (i_cpu_reset_ack)     next_state = ST_WAIT_LOAD;
            ST_WAIT_LOAD:  if (cmd_load)            next_state = ST_LOAD;
            ST_LOAD:       if (i_load_done)         next_state = ST_WAIT_START;
            ST_WAIT_START: if (cmd_run || cmd_step) next_state = ST_RUN;
            ST_RUN:        if (run_done)            next_state = ST_DUMP;
            ST_DUMP: begin
                if (!i_tx_busy) begin
                    // Step mode waits for the next step unless halted.
                    next_state = (step_mode_q && !i_cpu_halt) ? ST_WAIT_START : ST_IDLE;
                end
            end
            default:                                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state_q     <= ST_IDLE;
            step_mode_q <= 1'b0;
        end else begin
            state_q <= next_state;
            if (state_q == ST_WAIT_START) begin
                if (cmd_step) begin
                    step_mode_q <= 1'b1;
                end else if (cmd_run) begin
                    step_mode_q <= 1'b0;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Outputs
    //////////////////////////////////////////////////

    assign o_cpu_reset   = state_q == ST_SOFT_RESET;
    assign o_cpu_enable  = state_q == ST_RUN;
    assign o_load_active = state_q == ST_LOAD;
    assign o_send_ready  = (state_q == ST_SOFT_RESET) && i_cpu_reset_ack;  // Leaving reset.
    assign o_dump_start  = run_done;

endmodule

/* host_tx_engine.sv */
`timescale 1ns/1ps

module host_tx_engine import debug_pkg::*; (
    input  logic                  i_clock,
    input  logic                  i_reset,
    input  logic                  i_send_ready,
    input  logic                  i_dump_start,
    input  logic                  i_tx_credit,
    input  logic [WORD_W-1:0]     i_dump_word,
    output logic                  o_tx_valid,
    output logic [BYTE_W-1:0]     o_tx_data,
    output logic [DUMP_IDX_W-1:0] o_dump_index,
    output logic                  o_tx_busy
);

    logic [CREDIT_W-1:0]   credit_q;
    logic                  ready_pend_q;  // READY_BYTE still to go.
    logic                  dump_act_q;    // Dump in progress.
    logic [BYTE_IDX_W-1:0] byte_pos_q;    // 0 is the top byte.
    logic [DUMP_IDX_W-1:0] dump_idx_q;
    logic                  send;
    logic                  last_byte;
    logic                  last_word;
    logic [BYTE_W-1:0]     dump_byte;

    assign send      = (credit_q != '0) && (ready_pend_q || dump_act_q);
    assign last_byte = byte_pos_q == BYTE_IDX_W'(BYTES_PER_WORD - 1);
    assign last_word = dump_idx_q == DUMP_IDX_W'(DUMP_WORDS - 1);
    assign dump_byte = i_dump_word[(BYTES_PER_WORD - 1 - byte_pos_q) * BYTE_W +: BYTE_W];

    //////////////////////////////////////////////////
    // Credit counter
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            credit_q <= CREDIT_W'(TX_CREDITS);
        end else if (send && !i_tx_credit) begin
            credit_q <= credit_q - 1'b1;
        end else if (!send && i_tx_credit && (credit_q != CREDIT_W'(TX_CREDITS))) begin
            credit_q <= credit_q + 1'b1;  // Saturates at TX_CREDITS.
        end
    end

    //////////////////////////////////////////////////
    // Byte sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            ready_pend_q <= 1'b0;
            dump_act_q   <= 1'b0;
            byte_pos_q   <= '0;
            dump_idx_q   <= '0;
            o_tx_valid   <= 1'b0;
        end else begin
            o_tx_valid <= send;
            if (send && ready_pend_q) begin
                ready_pend_q <= 1'b0;  // Ready byte goes ahead of any dump.
            end else if (send) begin
                byte_pos_q <= last_byte ? '0 : byte_pos_q + 1'b1;
                if (last_byte && last_word) begin
                    dump_act_q <= 1'b0;
                    dump_idx_q <= '0;
                end else if (last_byte) begin
                    dump_idx_q <= dump_idx_q + 1'b1;
                end
            end
            if (i_send_ready) begin
                ready_pend_q <= 1'b1;
            end
            if (i_dump_start) begin
                dump_act_q <= 1'b1;
                byte_pos_q <= '0;
                dump_idx_q <= '0;
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (send) begin
            o_tx_data <= ready_pend_q ? READY_BYTE : dump_byte;
        end
    end

    assign o_dump_index = dump_idx_q;
    assign o_tx_busy    = ready_pend_q || dump_act_q;  // Low from the last byte on.

endmodule

/* program_loader.sv */
`timescale 1ns/1ps

module program_loader import debug_pkg::*; (
    input  logic                   i_clock,
    input  logic                   i_reset,
    input  logic                   i_load_active,
    input  logic                   i_byte_strobe,
    input  logic [BYTE_W-1:0]      i_rx_byte,
    output logic                   o_prog_write,
    output logic [PROG_ADDR_W-1:0] o_prog_addr,
    output logic [WORD_W-1:0]      o_prog_data,
    output logic                   o_load_done
);

    logic [WORD_W-1:0]      word_q;      // Assembly register.
    logic [WORD_W-1:0]      next_word;
    logic [BYTE_IDX_W-1:0]  byte_cnt_q;  // Bytes taken in this word.
    logic [PROG_ADDR_W-1:0] addr_q;
    logic                   take_byte;
    logic                   word_done;

    assign take_byte = i_load_active && i_byte_strobe;
    assign word_done = take_byte && (byte_cnt_q == BYTE_IDX_W'(BYTES_PER_WORD - 1));

    // First byte ends up in the top of the word.
    assign next_word = {word_q[WORD_W-BYTE_W-1:0], i_rx_byte};

    always_ff @(posedge i_clock) begin
        if (take_byte) begin
            word_q <= next_word;
        end
    end

    //////////////////////////////////////////////////
    // Byte count, write pulse and address
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset || !i_load_active) begin
            byte_cnt_q   <= '0;
            addr_q       <= '0;
            o_prog_write <= 1'b0;
            o_load_done  <= 1'b0;
        end else begin
            o_prog_write <= word_done;                             // One cycle after 4th byte.
            o_load_done  <= word_done && (next_word == HALT_WORD);
            if (take_byte) begin
                byte_cnt_q <= word_done ? '0 : byte_cnt_q + 1'b1;
            end
            if (o_prog_write) begin
                addr_q <= addr_q + 1'b1;  // Next word after the write.
            end
        end
    end

    assign o_prog_addr = addr_q;
    assign o_prog_data = word_q;  // Complete during the write cycle.

endmodule

/* rx_command_decoder.sv */
`timescale 1ns/1ps

module rx_command_decoder import debug_pkg::*; (
    input  logic              i_clock,
    input  logic              i_reset,
    input  logic              i_rx_done,
    input  logic [BYTE_W-1:0] i_rx_data,
    output logic              o_byte_strobe,
    output logic [BYTE_W-1:0] o_rx_byte,
    output cmd_e              o_rx_cmd
);

    logic rx_done_q;  // Previous sample of i_rx_done.
    logic rx_fall;

    function automatic cmd_e classify(input logic [BYTE_W-1:0] rx_byte);
        case (rx_byte)
            CMD_RESET, CMD_LOAD, CMD_RUN, CMD_STEP: classify = cmd_e'(rx_byte);
            default:                                classify = CMD_NONE;
        endcase
    endfunction

    assign rx_fall = rx_done_q && !i_rx_done;  // Receiver finished a byte.

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            rx_done_q     <= 1'b0;
            o_byte_strobe <= 1'b0;
            o_rx_cmd      <= CMD_NONE;
        end else begin
            rx_done_q     <= i_rx_done;
            o_byte_strobe <= rx_fall;
            if (rx_fall) begin
                o_rx_cmd <= classify(i_rx_data);
            end
        end
    end

    always_ff @(posedge i_clock) begin
        if (rx_fall) begin
            o_rx_byte <= i_rx_data;  // Held until the next byte.
        end
    end

endmodule

/* debug_pkg.sv */
package debug_pkg;

    //////////////////////////////////////////////////
    // Widths and counts
    //////////////////////////////////////////////////

    localparam int BYTE_W         = 8;   // UART byte.
    localparam int WORD_W         = 32;  // Instruction and debug word.
    localparam int BYTES_PER_WORD = 4;
    localparam int BYTE_IDX_W     = $clog2(BYTES_PER_WORD);
    localparam int PROG_ADDR_W    = 10;  // Program memory depth of 1K words.
    localparam int DUMP_WORDS     = 12;  // Debug words per dump.
    localparam int DUMP_IDX_W     = 4;
    localparam int TX_CREDITS     = 2;   // Bytes the host can buffer.
    localparam int CREDIT_W       = $clog2(TX_CREDITS + 1);

    //////////////////////////////////////////////////
    // Constants and encodings
    //////////////////////////////////////////////////

    localparam logic [WORD_W-1:0] HALT_WORD  = {WORD_W{1'b1}};  // Ends a program.
    localparam logic [BYTE_W-1:0] READY_BYTE = 8'h01;           // Soft reset complete.

    // Host command bytes.
    typedef enum logic [BYTE_W-1:0] {
        CMD_RESET = 8'h00,
        CMD_LOAD  = 8'h01,
        CMD_RUN   = 8'h03,
        CMD_STEP  = 8'h07,
        CMD_NONE  = 8'hff  // Any other byte.
    } cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SOFT_RESET,
        ST_WAIT_LOAD,
        ST_LOAD,
        ST_WAIT_START,
        ST_RUN,
        ST_DUMP
    } state_e;

endpackage
